//--- rtl/dsp_pkg.sv
// DSP slice package with operand widths, control codes, mux selects and pipeline constants
package dsp_pkg;

   // Operand and result widths
   typedef logic        [29:0] a_t;
   typedef logic signed [17:0] b_t;
   typedef logic        [47:0] c_t;
   typedef logic        [24:0] d_t;
   typedef logic signed [24:0] ad_t;
   typedef logic signed [42:0] pp_t;
   typedef logic        [47:0] p_t;

   // Control words
   typedef logic [6:0] opmode_t;
   typedef logic [3:0] alumode_t;
   typedef logic [2:0] inmode_t;

   // Legal ALUMODE codes
   typedef enum logic [3:0] {
      alu_add = 4'b0000,
      alu_sub = 4'b0011,
      alu_xor = 4'b0100,
      alu_and = 4'b1100
   } alu_op_e;

   // X mux, opmode bits 1..0
   localparam logic [1:0] x_sel_zero = 2'd0;
   localparam logic [1:0] x_sel_mult = 2'd1;
   localparam logic [1:0] x_sel_p    = 2'd2;
   localparam logic [1:0] x_sel_ab   = 2'd3;

   // Y mux, opmode bits 3..2
   localparam logic [1:0] y_sel_zero = 2'd0;
   localparam logic [1:0] y_sel_mult = 2'd1;
   localparam logic [1:0] y_sel_ones = 2'd2;
   localparam logic [1:0] y_sel_c    = 2'd3;

   // Z mux, opmode bits 6..4; codes 1 and 5 were cascade inputs
   localparam logic [2:0] z_sel_zero    = 3'd0;
   localparam logic [2:0] z_sel_p       = 3'd2;
   localparam logic [2:0] z_sel_c       = 3'd3;
   localparam logic [2:0] z_sel_p_alt   = 3'd4;
   localparam logic [2:0] z_sel_p_shift = 3'd6;

   // Partial product split and P feedback shift
   localparam int pp_split   = 9;
   localparam int b_hi_width = $bits(b_t) - pp_split;
   localparam int p_shift    = 17;

   // Set bits are don't-care in the pattern compare
   localparam p_t pattern_mask = 48'h0000_0000_00FF;

   // Edges from input sampling to P, counting the sampling edge
   localparam int slice_latency = 4;

endpackage

//--- rtl/operand_stage.sv
// Operand stage with A, B, C, D and control input registers, pre-adder and AD register
module operand_stage (
   input  logic              clk,
   input  logic              reset,
   input  dsp_pkg::a_t       a,
   input  dsp_pkg::b_t       b,
   input  dsp_pkg::c_t       c,
   input  dsp_pkg::d_t       d,
   input  dsp_pkg::inmode_t  inmode,
   input  dsp_pkg::opmode_t  opmode,
   input  dsp_pkg::alumode_t alumode,
   input  logic              carry_in,
   input  logic              in_valid,
   output dsp_pkg::ad_t      ad,
   output dsp_pkg::b_t       b2,
   output dsp_pkg::c_t       c2,
   output dsp_pkg::p_t       ab_cat,
   output dsp_pkg::opmode_t  opmode2,
   output dsp_pkg::alumode_t alumode2,
   output logic              carry2,
   output logic              s2_valid
);

   // First register stage
   dsp_pkg::a_t       a1;
   dsp_pkg::b_t       b1;
   dsp_pkg::c_t       c1;
   dsp_pkg::d_t       d1;
   dsp_pkg::inmode_t  inmode1;
   dsp_pkg::opmode_t  opmode1;
   dsp_pkg::alumode_t alumode1;
   logic              carry1;
   logic              s1_valid;

   // Pre-adder terms
   dsp_pkg::ad_t a_term;
   dsp_pkg::ad_t d_term;
   dsp_pkg::ad_t ad_sum;

   always_ff @(posedge clk) begin
      a1 <= a;
      b1 <= b;
      c1 <= c;
      d1 <= d;
   end

   // Control only moves with an accepted operation
   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid <= 1'b0;
         inmode1  <= '0;
         opmode1  <= '0;
         alumode1 <= '0;
         carry1   <= 1'b0;
      end else begin
         s1_valid <= in_valid;
         if (in_valid) begin
            inmode1  <= inmode;
            opmode1  <= opmode;
            alumode1 <= alumode;
            carry1   <= carry_in;
         end
      end
   end

   // Pre-adder on the low 25 bits of A, wraps at 25 bits
   assign a_term = inmode1[2] ? '0 : a1[$bits(dsp_pkg::ad_t)-1:0];
   assign d_term = inmode1[0] ? d1 : '0;
   assign ad_sum = inmode1[1] ? d_term - a_term : d_term + a_term;

   // AD, B2 and C2 registers, A:B taken from the first stage
   always_ff @(posedge clk) begin
      ad     <= ad_sum;
      b2     <= b1;
      c2     <= c1;
      ab_cat <= {a1, b1};
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         s2_valid <= 1'b0;
         opmode2  <= '0;
         alumode2 <= '0;
         carry2   <= 1'b0;
      end else begin
         s2_valid <= s1_valid;
         if (s1_valid) begin
            opmode2  <= opmode1;
            alumode2 <= alumode1;
            carry2   <= carry1;
         end
      end
   end

endmodule

//--- rtl/mult_stage.sv
// Multiplier stage forming two registered partial products of the signed 25x18 product
module mult_stage (
   input  logic              clk,
   input  logic              reset,
   input  dsp_pkg::ad_t      ad,
   input  dsp_pkg::b_t       b2,
   input  dsp_pkg::c_t       c2,
   input  dsp_pkg::p_t       ab_cat,
   input  dsp_pkg::opmode_t  opmode2,
   input  dsp_pkg::alumode_t alumode2,
   input  logic              carry2,
   input  logic              s2_valid,
   output dsp_pkg::pp_t      pp_x,
   output dsp_pkg::pp_t      pp_y,
   output dsp_pkg::c_t       m_c,
   output dsp_pkg::p_t       m_ab_cat,
   output dsp_pkg::opmode_t  m_opmode,
   output dsp_pkg::alumode_t m_alumode,
   output logic              m_carry,
   output logic              m_valid
);

   // Upper B bits keep the sign, lower bits are zero-extended
   logic signed [dsp_pkg::b_hi_width-1:0]                       b_hi;
   logic signed [dsp_pkg::pp_split:0]                           b_lo;
   logic signed [$bits(dsp_pkg::ad_t)+dsp_pkg::b_hi_width-1:0]  prod_hi;
   logic signed [$bits(dsp_pkg::ad_t)+dsp_pkg::pp_split:0]      prod_lo;

   assign b_hi = b2[$bits(dsp_pkg::b_t)-1:dsp_pkg::pp_split];
   assign b_lo = {1'b0, b2[dsp_pkg::pp_split-1:0]};

   assign prod_hi = ad * b_hi;
   assign prod_lo = ad * b_lo;

   // M register, pp_x + pp_y is the full product
   always_ff @(posedge clk) begin
      pp_x     <= {prod_hi, {dsp_pkg::pp_split{1'b0}}};
      pp_y     <= dsp_pkg::pp_t'(prod_lo);
      m_c      <= c2;
      m_ab_cat <= ab_cat;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         m_valid   <= 1'b0;
         m_opmode  <= '0;
         m_alumode <= '0;
         m_carry   <= 1'b0;
      end else begin
         m_valid <= s2_valid;
         if (s2_valid) begin
            m_opmode  <= opmode2;
            m_alumode <= alumode2;
            m_carry   <= carry2;
         end
      end
   end

endmodule

//--- rtl/opmode_mux.sv
// X, Y and Z operand multiplexers selected by the 7-bit opmode
module opmode_mux (
   input  dsp_pkg::pp_t     pp_x,
   input  dsp_pkg::pp_t     pp_y,
   input  dsp_pkg::p_t      ab_cat,
   input  dsp_pkg::c_t      c,
   input  dsp_pkg::p_t      p,
   input  dsp_pkg::opmode_t opmode,
   output dsp_pkg::p_t      x,
   output dsp_pkg::p_t      y,
   output dsp_pkg::p_t      z
);

   dsp_pkg::p_t pp_x_ext;
   dsp_pkg::p_t pp_y_ext;
   dsp_pkg::p_t p_sra;

   // Partial products sign-extended to the ALU width
   assign pp_x_ext = {{($bits(dsp_pkg::p_t)-$bits(dsp_pkg::pp_t)){pp_x[$bits(dsp_pkg::pp_t)-1]}},
                      pp_x};
   assign pp_y_ext = {{($bits(dsp_pkg::p_t)-$bits(dsp_pkg::pp_t)){pp_y[$bits(dsp_pkg::pp_t)-1]}},
                      pp_y};

   // Arithmetic right shift of P for wide accumulation
   assign p_sra = {{dsp_pkg::p_shift{p[$bits(dsp_pkg::p_t)-1]}},
                   p[$bits(dsp_pkg::p_t)-1:dsp_pkg::p_shift]};

   always_comb begin
      case (opmode[1:0])
         dsp_pkg::x_sel_zero: x = '0;
         dsp_pkg::x_sel_mult: x = pp_x_ext;
         dsp_pkg::x_sel_p:    x = p;
         dsp_pkg::x_sel_ab:   x = ab_cat;
         default:             x = '0;
      endcase
   end

   always_comb begin
      case (opmode[3:2])
         dsp_pkg::y_sel_zero: y = '0;
         dsp_pkg::y_sel_mult: y = pp_y_ext;
         dsp_pkg::y_sel_ones: y = '1;
         dsp_pkg::y_sel_c:    y = c;
         default:             y = '0;
      endcase
   end

   // Code 4 also gives P, cascade codes fall to zero
   always_comb begin
      case (opmode[6:4])
         dsp_pkg::z_sel_zero:    z = '0;
         dsp_pkg::z_sel_p:       z = p;
         dsp_pkg::z_sel_c:       z = c;
         dsp_pkg::z_sel_p_alt:   z = p;
         dsp_pkg::z_sel_p_shift: z = p_sra;
         default:                z = '0;
      endcase
   end

   // A lone partial product would drop half of the multiplier result
   always_comb begin
      assert ((opmode[1:0] == dsp_pkg::x_sel_mult) == (opmode[3:2] == dsp_pkg::y_sel_mult))
         else $error("opmode selects only one partial product");
   end

endmodule

//--- rtl/dsp_alu.sv
// 48-bit ALU with add, subtract and logic modes and the accumulating P register
module dsp_alu (
   input  logic              clk,
   input  logic              reset,
   input  dsp_pkg::p_t       x,
   input  dsp_pkg::p_t       y,
   input  dsp_pkg::p_t       z,
   input  dsp_pkg::alumode_t alumode,
   input  logic              carry_in,
   input  logic              m_valid,
   output dsp_pkg::p_t       p_next,
   output dsp_pkg::p_t       p,
   output logic              carry_out,
   output logic              p_valid
);

   dsp_pkg::alu_op_e alu_op;

   // Arithmetic is done two bits wider than P
   logic [$bits(dsp_pkg::p_t)+1:0] wide;
   logic                           carry_next;

   assign alu_op = dsp_pkg::alu_op_e'(alumode);

   always_comb begin
      wide       = '0;
      p_next     = '0;
      carry_next = 1'b0;
      case (alu_op)
         dsp_pkg::alu_add: begin
            wide       = 50'(z) + 50'(x) + 50'(y) + 50'(carry_in);
            p_next     = wide[$bits(dsp_pkg::p_t)-1:0];
            carry_next = wide[$bits(dsp_pkg::p_t)];
         end
         dsp_pkg::alu_sub: begin
            wide       = 50'(z) - (50'(x) + 50'(y) + 50'(carry_in));
            p_next     = wide[$bits(dsp_pkg::p_t)-1:0];
            carry_next = wide[$bits(dsp_pkg::p_t)];
         end
         // Two-input logic modes ignore Y and the carry
         dsp_pkg::alu_xor: p_next = x ^ z;
         dsp_pkg::alu_and: p_next = x & z;
         default:          p_next = '0;
      endcase
   end

   // P holds between operations so accumulation chains across gaps
   always_ff @(posedge clk) begin
      if (reset) begin
         p         <= '0;
         carry_out <= 1'b0;
         p_valid   <= 1'b0;
      end else begin
         p_valid <= m_valid;
         if (m_valid) begin
            p         <= p_next;
            carry_out <= carry_next;
         end
      end
   end

   // Alumode entered at the slice input must be one of the decoded codes
   a_legal_alumode: assert property (
      @(posedge clk) disable iff (reset)
      m_valid |-> alumode inside {dsp_pkg::alu_add, dsp_pkg::alu_sub,
                                  dsp_pkg::alu_xor, dsp_pkg::alu_and}
   ) else $error("illegal alumode on a valid operation");

endmodule

//--- rtl/pattern_detect.sv
// Pattern detector comparing the next P against C and its complement under the mask
module pattern_detect (
   input  logic        clk,
   input  logic        reset,
   input  dsp_pkg::p_t p_next,
   input  dsp_pkg::c_t c,
   input  logic        m_valid,
   output logic        pattern_detect,
   output logic        pattern_b_detect
);

   logic match;
   logic match_b;

   // Masked bits never count as a mismatch
   assign match   = ((p_next ^ c) & ~dsp_pkg::pattern_mask) == '0;
   assign match_b = ((p_next ^ ~c) & ~dsp_pkg::pattern_mask) == '0;

   // Flags line up with the P register load
   always_ff @(posedge clk) begin
      if (reset) begin
         pattern_detect   <= 1'b0;
         pattern_b_detect <= 1'b0;
      end else if (m_valid) begin
         pattern_detect   <= match;
         pattern_b_detect <= match_b;
      end
   end

endmodule

//--- rtl/dsp_slice.sv
// Pipelined DSP slice top level connecting operand, multiplier, mux, ALU and pattern stages
module dsp_slice (
   input  logic              clk,
   input  logic              reset,
   input  dsp_pkg::a_t       a,
   input  dsp_pkg::b_t       b,
   input  dsp_pkg::c_t       c,
   input  dsp_pkg::d_t       d,
   input  dsp_pkg::inmode_t  inmode,
   input  dsp_pkg::opmode_t  opmode,
   input  dsp_pkg::alumode_t alumode,
   input  logic              carry_in,
   input  logic              in_valid,
   output dsp_pkg::p_t       p,
   output logic              carry_out,
   output logic              pattern_detect,
   output logic              pattern_b_detect,
   output logic              p_valid
);

   // Operand stage to multiplier
   dsp_pkg::ad_t      ad;
   dsp_pkg::b_t       b2;
   dsp_pkg::c_t       c2;
   dsp_pkg::p_t       ab_cat;
   dsp_pkg::opmode_t  opmode2;
   dsp_pkg::alumode_t alumode2;
   logic              carry2;
   logic              s2_valid;

   // Multiplier stage to muxes and ALU
   dsp_pkg::pp_t      pp_x;
   dsp_pkg::pp_t      pp_y;
   dsp_pkg::c_t       m_c;
   dsp_pkg::p_t       m_ab_cat;
   dsp_pkg::opmode_t  m_opmode;
   dsp_pkg::alumode_t m_alumode;
   logic              m_carry;
   logic              m_valid;

   dsp_pkg::p_t x;
   dsp_pkg::p_t y;
   dsp_pkg::p_t z;
   dsp_pkg::p_t p_next;

   operand_stage i_operand_stage (
      .clk(clk), .reset(reset), .a(a), .b(b), .c(c), .d(d),
      .inmode(inmode), .opmode(opmode), .alumode(alumode), .carry_in(carry_in),
      .in_valid(in_valid), .ad(ad), .b2(b2), .c2(c2), .ab_cat(ab_cat),
      .opmode2(opmode2), .alumode2(alumode2), .carry2(carry2), .s2_valid(s2_valid)
   );

   mult_stage i_mult_stage (
      .clk(clk), .reset(reset), .ad(ad), .b2(b2), .c2(c2), .ab_cat(ab_cat),
      .opmode2(opmode2), .alumode2(alumode2), .carry2(carry2), .s2_valid(s2_valid),
      .pp_x(pp_x), .pp_y(pp_y), .m_c(m_c), .m_ab_cat(m_ab_cat), .m_opmode(m_opmode),
      .m_alumode(m_alumode), .m_carry(m_carry), .m_valid(m_valid)
   );

   opmode_mux i_opmode_mux (
      .pp_x(pp_x), .pp_y(pp_y), .ab_cat(m_ab_cat), .c(m_c), .p(p),
      .opmode(m_opmode), .x(x), .y(y), .z(z)
   );

   dsp_alu i_dsp_alu (
      .clk(clk), .reset(reset), .x(x), .y(y), .z(z), .alumode(m_alumode),
      .carry_in(m_carry), .m_valid(m_valid), .p_next(p_next), .p(p),
      .carry_out(carry_out), .p_valid(p_valid)
   );

   pattern_detect i_pattern_detect (
      .clk(clk), .reset(reset), .p_next(p_next), .c(m_c), .m_valid(m_valid),
      .pattern_detect(pattern_detect), .pattern_b_detect(pattern_b_detect)
   );

endmodule

//--- test/tb_dsp_slice.sv
// Testbench for the DSP slice that checks P, carry and pattern flags against a reference model
module tb_dsp_slice;

   typedef struct packed {
      dsp_pkg::a_t       a;
      dsp_pkg::b_t       b;
      dsp_pkg::c_t       c;
      dsp_pkg::d_t       d;
      dsp_pkg::inmode_t  inmode;
      dsp_pkg::opmode_t  opmode;
      dsp_pkg::alumode_t alumode;
      logic              carry;
   } op_t;

   typedef struct packed {
      dsp_pkg::p_t p;
      logic        carry;
      logic        pat;
      logic        pat_b;
   } result_t;

   localparam int reset_cycles = 16;
   localparam int num_ops      = 112;
   localparam int gap_ops      = 16;
   localparam int max_gap      = 3;
   localparam int run_cycles   = reset_cycles + num_ops + gap_ops * max_gap
                                 + dsp_pkg::slice_latency + 50;

   logic              clk;
   logic              reset;
   dsp_pkg::a_t       a;
   dsp_pkg::b_t       b;
   dsp_pkg::c_t       c;
   dsp_pkg::d_t       d;
   dsp_pkg::inmode_t  inmode;
   dsp_pkg::opmode_t  opmode;
   dsp_pkg::alumode_t alumode;
   logic              carry_in;
   logic              in_valid;
   dsp_pkg::p_t       p;
   logic              carry_out;
   logic              pattern_detect;
   logic              pattern_b_detect;
   logic              p_valid;

   op_t         pending[$];
   int          accept_edge[$];
   int          edge_count = 0;
   int          error_count = 0;
   int          check_count = 0;
   int          results_seen = 0;
   dsp_pkg::p_t model_p = '0;
   logic [63:0] rand_state = 64'd73;

   dsp_slice i_dsp_slice (
      .clk(clk), .reset(reset), .a(a), .b(b), .c(c), .d(d), .inmode(inmode),
      .opmode(opmode), .alumode(alumode), .carry_in(carry_in), .in_valid(in_valid),
      .p(p), .carry_out(carry_out), .pattern_detect(pattern_detect),
      .pattern_b_detect(pattern_b_detect), .p_valid(p_valid)
   );

   always #10 clk = ~clk;

   function automatic logic [63:0] next_random();
      rand_state = rand_state ^ (rand_state << 13);
      rand_state = rand_state ^ (rand_state >> 7);
      rand_state = rand_state ^ (rand_state << 17);
      return rand_state;
   endfunction

   function automatic dsp_pkg::opmode_t make_opmode(input logic [2:0] zs, input logic [1:0] ys,
                                                    input logic [1:0] xs);
      return {zs, ys, xs};
   endfunction

   // Default is a multiply-add with D+A in the pre-adder
   function automatic op_t random_op();
      op_t op;
      op.a       = dsp_pkg::a_t'(next_random());
      op.b       = dsp_pkg::b_t'(next_random());
      op.c       = dsp_pkg::c_t'(next_random());
      op.d       = dsp_pkg::d_t'(next_random());
      op.inmode  = 3'b001;
      op.opmode  = make_opmode(dsp_pkg::z_sel_c, dsp_pkg::y_sel_mult, dsp_pkg::x_sel_mult);
      op.alumode = dsp_pkg::alu_add;
      op.carry   = 1'b0;
      return op;
   endfunction

   // Expected slice result for one operation given the P of the previous one
   function automatic result_t reference_result(input op_t op, input dsp_pkg::p_t prev_p);
      dsp_pkg::ad_t a_part;
      dsp_pkg::ad_t d_part;
      dsp_pkg::ad_t ad;
      longint       pp_hi;
      longint       pp_lo;
      dsp_pkg::p_t  x;
      dsp_pkg::p_t  y;
      dsp_pkg::p_t  z;
      logic [49:0]  sum;
      result_t      r;
      a_part = op.inmode[2] ? '0 : dsp_pkg::ad_t'(op.a[24:0]);
      d_part = op.inmode[0] ? dsp_pkg::ad_t'(op.d) : '0;
      ad     = op.inmode[1] ? d_part - a_part : d_part + a_part;
      // Signed upper B times AD, shifted, plus unsigned lower B times AD
      pp_hi  = (longint'(ad) * longint'($signed(op.b[17:dsp_pkg::pp_split])))
               <<< dsp_pkg::pp_split;
      pp_lo  = longint'(ad) * longint'(op.b[dsp_pkg::pp_split-1:0]);
      case (op.opmode[1:0])
         dsp_pkg::x_sel_mult: x = dsp_pkg::p_t'(pp_hi);
         dsp_pkg::x_sel_p:    x = prev_p;
         dsp_pkg::x_sel_ab:   x = {op.a, op.b};
         default:             x = '0;
      endcase
      case (op.opmode[3:2])
         dsp_pkg::y_sel_mult: y = dsp_pkg::p_t'(pp_lo);
         dsp_pkg::y_sel_ones: y = '1;
         dsp_pkg::y_sel_c:    y = op.c;
         default:             y = '0;
      endcase
      case (op.opmode[6:4])
         3'd2, 3'd4: z = prev_p;
         3'd3:       z = op.c;
         3'd6:       z = dsp_pkg::p_t'($signed(prev_p) >>> dsp_pkg::p_shift);
         default:    z = '0;
      endcase
      r.carry = 1'b0;
      case (op.alumode)
         4'b0000: begin
            sum     = {2'b00, z} + {2'b00, x} + {2'b00, y} + {49'd0, op.carry};
            r.p     = sum[47:0];
            r.carry = sum[48];
         end
         4'b0011: begin
            sum     = {2'b00, z} - ({2'b00, x} + {2'b00, y} + {49'd0, op.carry});
            r.p     = sum[47:0];
            r.carry = sum[48];
         end
         4'b0100: r.p = x ^ z;
         4'b1100: r.p = x & z;
         default: r.p = '0;
      endcase
      r.pat   = ((r.p ^ op.c) & ~dsp_pkg::pattern_mask) == '0;
      r.pat_b = ((r.p ^ ~op.c) & ~dsp_pkg::pattern_mask) == '0;
      return r;
   endfunction

   task automatic check_p(input string name, input dsp_pkg::p_t expected,
                          input dsp_pkg::p_t actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
      end
   endtask

   task automatic issue_op(input op_t op);
      @(posedge clk);
      a        <= op.a;
      b        <= op.b;
      c        <= op.c;
      d        <= op.d;
      inmode   <= op.inmode;
      opmode   <= op.opmode;
      alumode  <= op.alumode;
      carry_in <= op.carry;
      in_valid <= 1'b1;
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(posedge clk);
         in_valid <= 1'b0;
      end
   endtask

   // Record each operation on the edge that accepts it
   always @(posedge clk) begin
      edge_count <= edge_count + 1;
      if (!reset && in_valid) begin
         pending.push_back({a, b, c, d, inmode, opmode, alumode, carry_in});
         accept_edge.push_back(edge_count);
      end
   end

   always @(posedge clk) begin : compare_results
      op_t     done_op;
      result_t expected;
      int      latency;
      if (!reset && p_valid) begin
         if (pending.size() == 0) begin
            error_count++;
            $display("p_valid was raised with no operation pending");
         end else begin
            done_op = pending.pop_front();
            latency = edge_count - accept_edge.pop_front();
            results_seen++;
            if (latency != dsp_pkg::slice_latency) begin
               error_count++;
               $display("result arrived %0d edges after its operation instead of %0d",
                        latency, dsp_pkg::slice_latency);
            end
            expected = reference_result(done_op, model_p);
            model_p  = expected.p;
            check_p("p", expected.p, p);
            check_flag("carry_out", expected.carry, carry_out);
            check_flag("pattern_detect", expected.pat, pattern_detect);
            check_flag("pattern_b_detect", expected.pat_b, pattern_b_detect);
         end
      end
   end

   initial begin
      #(run_cycles * 20);
      $display("watchdog expired before all operations completed");
      $display("tests failed");
      $finish;
   end

   initial begin
      op_t op;
      int  i;
      clk      = 1'b0;
      reset    = 1'b1;
      a        = '0;
      b        = '0;
      c        = '0;
      d        = '0;
      inmode   = '0;
      opmode   = '0;
      alumode  = '0;
      carry_in = 1'b0;
      in_valid = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      check_p("p", '0, p);
      check_flag("p_valid", 1'b0, p_valid);
      check_flag("carry_out", 1'b0, carry_out);
      check_flag("pattern_detect", 1'b0, pattern_detect);
      check_flag("pattern_b_detect", 1'b0, pattern_b_detect);
      // Multiply-add with D+A, D-A and A only
      for (i = 0; i < 24; i++) begin
         op = random_op();
         op.inmode = (i % 3 == 0) ? 3'b001 : (i % 3 == 1) ? 3'b011 : 3'b000;
         issue_op(op);
      end
      // Back-to-back accumulation on P, then on P shifted
      for (i = 0; i < 32; i++) begin
         op = random_op();
         op.opmode = make_opmode((i < 16) ? dsp_pkg::z_sel_p : dsp_pkg::z_sel_p_shift,
                                 dsp_pkg::y_sel_mult, dsp_pkg::x_sel_mult);
         issue_op(op);
      end
      // Accumulation with random idle gaps
      for (i = 0; i < gap_ops; i++) begin
         op = random_op();
         op.opmode = make_opmode(i[0] ? dsp_pkg::z_sel_p_shift : dsp_pkg::z_sel_p,
                                 dsp_pkg::y_sel_mult, dsp_pkg::x_sel_mult);
         issue_op(op);
         idle(int'(next_random() % (max_gap + 1)));
      end
      // Subtract with both carry values, then XOR and AND on A:B and C
      for (i = 0; i < 16; i++) begin
         op = random_op();
         op.opmode  = make_opmode(dsp_pkg::z_sel_c, dsp_pkg::y_sel_zero, dsp_pkg::x_sel_ab);
         op.alumode = (i % 4 < 2) ? dsp_pkg::alu_sub :
                      (i % 4 == 2) ? dsp_pkg::alu_xor : dsp_pkg::alu_and;
         op.carry   = i[0];
         issue_op(op);
      end
      // C minus one, C pass-through and A:B pass-through
      for (i = 0; i < 8; i++) begin
         op = random_op();
         case (i % 4)
            0, 1: op.opmode = make_opmode(dsp_pkg::z_sel_c, dsp_pkg::y_sel_ones,
                                          dsp_pkg::x_sel_zero);
            2:    op.opmode = make_opmode(dsp_pkg::z_sel_c, dsp_pkg::y_sel_zero,
                                          dsp_pkg::x_sel_zero);
            default: op.opmode = make_opmode(dsp_pkg::z_sel_zero, dsp_pkg::y_sel_zero,
                                             dsp_pkg::x_sel_ab);
         endcase
         issue_op(op);
      end
      // Pattern hits on C and on its complement, with random cases mixed in
      for (i = 0; i < 16; i++) begin
         op = random_op();
         if (i % 4 != 3) begin
            op.opmode = make_opmode(dsp_pkg::z_sel_zero, dsp_pkg::y_sel_zero,
                                    dsp_pkg::x_sel_ab);
         end
         if (i % 4 == 0)
            op.c = {op.a, op.b} ^ (dsp_pkg::p_t'(next_random()) & dsp_pkg::pattern_mask);
         else if (i % 4 == 1)
            op.c = ~{op.a, op.b} ^ (dsp_pkg::p_t'(next_random()) & dsp_pkg::pattern_mask);
         issue_op(op);
      end
      idle(1);
      repeat (2) @(posedge clk);
      while (pending.size() != 0) @(posedge clk);
      repeat (2) @(posedge clk);
      if (results_seen != num_ops) begin
         error_count++;
         $display("expected %0d results but saw %0d", num_ops, results_seen);
      end
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- dsp_slice.f
rtl/dsp_pkg.sv
rtl/operand_stage.sv
rtl/mult_stage.sv
rtl/opmode_mux.sv
rtl/dsp_alu.sv
rtl/pattern_detect.sv
rtl/dsp_slice.sv
test/tb_dsp_slice.sv

//--- run_sim.sh
#!/bin/sh
# Build the DSP slice testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f dsp_slice.f \
   --top-module tb_dsp_slice -o tb_dsp_slice || { echo "build error"; exit 1; }
out=$(./obj_dir/tb_dsp_slice)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }
